// File: logic/fb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 at 60 Hz only, all logic on one pixel clock (25.2 MHz)
// framebuffer fixed at 160x120 with one bit per pixel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fb_pkg;
    localparam int CORDW   = 10;   // screen coordinate width
    localparam int H_RES   = 640;  // visible pixels per line
    localparam int V_RES   = 480;  // visible lines
    localparam int H_FP    = 16;
    localparam int H_SYNC  = 96;
    localparam int H_BP    = 48;
    localparam int V_FP    = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 33;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    // sync windows, start inclusive and end exclusive
    localparam int H_SYNC_START = H_RES + H_FP;            // 656
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;   // 752
    localparam int V_SYNC_START = V_RES + V_FP;            // 490
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;   // 492
    localparam logic [CORDW-1:0] H_LAST = CORDW'(H_TOTAL - 1);
    localparam logic [CORDW-1:0] V_LAST = CORDW'(V_TOTAL - 1);

    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 19200
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);     // 15 bits
    localparam logic [FB_ADDRW-1:0] FB_LAST = FB_ADDRW'(FB_PIXELS - 1);
    localparam int PIPE_DELAY = 2;  // coordinate to vga pin

    // apb register map
    localparam int APB_ADDRW = 8;
    localparam logic [APB_ADDRW-1:0] REG_CTRL    = 8'h00;  // bit 0 enable
    localparam logic [APB_ADDRW-1:0] REG_FG      = 8'h04;
    localparam logic [APB_ADDRW-1:0] REG_BG      = 8'h08;
    localparam logic [APB_ADDRW-1:0] REG_FB_ADDR = 8'h0C;
    localparam logic [APB_ADDRW-1:0] REG_FB_DATA = 8'h10;  // write only

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } colour_t;

    typedef struct packed {
        logic [CORDW-1:0] sx;
        logic [CORDW-1:0] sy;
        logic             hsync;  // active low
        logic             vsync;  // active low
        logic             de;
    } scan_pos_t;

    typedef struct packed {
        logic    enable;
        colour_t fg;
        colour_t bg;
    } fb_cfg_t;

    typedef struct packed {
        logic                en;
        logic [FB_ADDRW-1:0] addr;
        logic                data;
    } fb_wr_t;
endpackage

// File: logic/display_timings.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// negative sync polarity, counts restart at 0,0 on reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module display_timings (
    input  logic              clk_pix,
    input  logic              reset,
    output fb_pkg::scan_pos_t pos
);
    logic [fb_pkg::CORDW-1:0] sx;  // horizontal position incl blanking
    logic [fb_pkg::CORDW-1:0] sy;  // vertical position incl blanking
    logic                     line_end;
    logic                     frame_end;

    assign line_end  = (sx == fb_pkg::H_LAST);
    assign frame_end = line_end && (sy == fb_pkg::V_LAST);

    // raster counters over the full 800x525
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (frame_end) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= sy + 1'b1;  // next line
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decode syncs and data enable from the counters
    always_comb begin
        pos.sx    = sx;
        pos.sy    = sy;
        // low inside the sync window
        pos.hsync = ~((sx >= fb_pkg::H_SYNC_START) && (sx < fb_pkg::H_SYNC_END));
        pos.vsync = ~((sy >= fb_pkg::V_SYNC_START) && (sy < fb_pkg::V_SYNC_END));
        pos.de    = (sx < fb_pkg::H_RES) && (sy < fb_pkg::V_RES);  // visible area
    end

    // counters must never leave the raster
    a_coord_range: assert property (
        @(posedge clk_pix) disable iff (reset)
        (sx < fb_pkg::H_TOTAL) && (sy < fb_pkg::V_TOTAL)
    ) else $error("display_timings: sx %0d sy %0d outside raster", sx, sy);
endmodule

// File: logic/bram_sdp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read data one cycle after address, collision returns old bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module bram_sdp (
    input  logic                        clk_pix,
    input  fb_pkg::fb_wr_t              wr,
    input  logic [fb_pkg::FB_ADDRW-1:0] rd_addr,
    output logic                        rd_data
);
    logic mem [0:fb_pkg::FB_PIXELS-1];  // one bit per pixel

    // framebuffer starts cleared
    initial begin
        for (int i = 0; i < fb_pkg::FB_PIXELS; i++) begin
            mem[i] = 1'b0;
        end
    end

    // single process so a same-address read sees the old value
    always_ff @(posedge clk_pix) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];  // registered read
    end

    // writer has to keep its address inside the framebuffer
    a_wr_range: assert property (
        @(posedge clk_pix)
        wr.en |-> (wr.addr < fb_pkg::FB_PIXELS)
    ) else $error("bram_sdp: write address %0d out of range", wr.addr);
endmodule

// File: logic/fb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb3 slave with zero wait states, fb_data is write only
// fb_addr writes beyond the last pixel load address 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fb_regs (
    input  logic                         clk_pix,
    input  logic                         reset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [fb_pkg::APB_ADDRW-1:0] paddr,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output fb_pkg::fb_cfg_t              cfg,
    output fb_pkg::fb_wr_t               fb_wr
);
    logic                        apb_access;  // second cycle of a transfer
    logic                        apb_wr;
    logic                        apb_rd;
    logic                        addr_hit;    // paddr is in the map
    logic                        data_wr;     // write to fb_data
    logic [fb_pkg::FB_ADDRW-1:0] fb_addr;     // next pixel to write
    logic [fb_pkg::FB_ADDRW-1:0] fb_addr_next;
    logic [fb_pkg::FB_ADDRW-1:0] new_addr;
    logic                        wr_en_q;
    logic [fb_pkg::FB_ADDRW-1:0] wr_addr_q;
    logic                        wr_data_q;

    assign apb_access   = psel && penable;
    assign apb_wr       = apb_access && pwrite;
    assign apb_rd       = apb_access && !pwrite;
    assign data_wr      = apb_wr && (paddr == fb_pkg::REG_FB_DATA);
    assign pready       = 1'b1;  // never waits
    assign new_addr     = pwdata[fb_pkg::FB_ADDRW-1:0];
    assign fb_addr_next = (fb_addr == fb_pkg::FB_LAST) ? '0 : fb_addr + 1'b1;  // wraps

    // read mux and address decode
    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            fb_pkg::REG_CTRL:    prdata = {31'b0, cfg.enable};
            fb_pkg::REG_FG:      prdata = {20'b0, cfg.fg};
            fb_pkg::REG_BG:      prdata = {20'b0, cfg.bg};
            fb_pkg::REG_FB_ADDR: prdata = {17'b0, fb_addr};
            fb_pkg::REG_FB_DATA: prdata = '0;  // nothing to read back
            default:             addr_hit = 1'b0;
        endcase
        if (!apb_rd) begin
            prdata = '0;  // only valid in a read access
        end
    end

    assign pslverr = apb_access &&
                     (!addr_hit || (!pwrite && (paddr == fb_pkg::REG_FB_DATA)));

    // config and address registers, writes land at end of access
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            cfg     <= '0;
            fb_addr <= '0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= data_wr;  // one cycle pulse per data write
            if (apb_wr) begin
                case (paddr)
                    fb_pkg::REG_CTRL: cfg.enable <= pwdata[0];
                    fb_pkg::REG_FG:   cfg.fg <= fb_pkg::colour_t'(pwdata[11:0]);
                    fb_pkg::REG_BG:   cfg.bg <= fb_pkg::colour_t'(pwdata[11:0]);
                    fb_pkg::REG_FB_ADDR: begin
                        fb_addr <= (new_addr < fb_pkg::FB_PIXELS) ? new_addr : '0;
                    end
                    fb_pkg::REG_FB_DATA: fb_addr <= fb_addr_next;  // auto increment
                    default: ;
                endcase
            end
        end
    end

    // write payload, taken with the current address
    always_ff @(posedge clk_pix) begin
        if (data_wr) begin
            wr_addr_q <= fb_addr;
            wr_data_q <= pwdata[0];
        end
    end

    assign fb_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    // master must hold address and direction across setup and access
    a_setup_stable: assert property (
        @(posedge clk_pix) disable iff (reset)
        (psel && !penable) ##1 penable |-> $stable(paddr) && $stable(pwrite)
    ) else $error("fb_regs: paddr or pwrite changed between setup and access");

    a_penable_psel: assert property (
        @(posedge clk_pix) disable iff (reset)
        penable |-> psel
    ) else $error("fb_regs: penable high without psel");
endmodule

// File: logic/fb_scanout.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed two cycle pipe from pos to pins, needs one cycle ram read
// framebuffer region is the top left 160x120 at 1:1 scale
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fb_scanout (
    input  logic                        clk_pix,
    input  logic                        reset,
    input  fb_pkg::scan_pos_t           pos,
    input  fb_pkg::fb_cfg_t             cfg,
    output logic [fb_pkg::FB_ADDRW-1:0] rd_addr,
    input  logic                        rd_data,
    output logic                        vga_hsync,
    output logic                        vga_vsync,
    output fb_pkg::colour_t             vga_colour
);
    logic            in_fb;       // pos inside framebuffer region
    logic            frame_end;
    logic            in_fb_q;     // stage 1 copies
    logic            hsync_q;
    logic            vsync_q;
    fb_pkg::colour_t pix_colour;  // colour chosen from ram bit

    assign in_fb = pos.de &&
                   (pos.sx < fb_pkg::FB_WIDTH) && (pos.sy < fb_pkg::FB_HEIGHT);
    assign frame_end = (pos.sx == fb_pkg::H_LAST) && (pos.sy == fb_pkg::V_LAST);

    // raster order read address
    // rd_addr already holds the address of the pixel at pos
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            rd_addr <= '0;
        end else if (frame_end) begin
            rd_addr <= '0;  // back to top left for next frame
        end else if (in_fb) begin
            // wrap after the last pixel so the address never leaves the ram
            rd_addr <= (rd_addr == fb_pkg::FB_LAST) ? '0 : rd_addr + 1'b1;
        end
    end

    // stage 1 while the ram reads
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            in_fb_q <= 1'b0;
            hsync_q <= 1'b1;  // inactive
            vsync_q <= 1'b1;
        end else begin
            in_fb_q <= in_fb;
            hsync_q <= pos.hsync;
            vsync_q <= pos.vsync;
        end
    end

    always_comb begin
        if (!cfg.enable || !in_fb_q) begin
            pix_colour = '0;  // black outside region or disabled
        end else if (rd_data) begin
            pix_colour = cfg.fg;
        end else begin
            pix_colour = cfg.bg;
        end
    end

    // stage 2 registers all pins together so they stay aligned
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga_colour <= '0;
            vga_hsync  <= 1'b1;
            vga_vsync  <= 1'b1;
        end else begin
            vga_colour <= pix_colour;
            vga_hsync  <= hsync_q;
            vga_vsync  <= vsync_q;
        end
    end

    // address counter and region size have to agree
    a_rd_range: assert property (
        @(posedge clk_pix) disable iff (reset)
        rd_addr < fb_pkg::FB_PIXELS
    ) else $error("fb_scanout: read address %0d out of range", rd_addr);
endmodule

// File: logic/fb_display_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb and vga share clk_pix, reset stands in for pll lock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fb_display_top (
    input  logic                         clk_pix,
    input  logic                         reset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [fb_pkg::APB_ADDRW-1:0] paddr,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         vga_hsync,
    output logic                         vga_vsync,
    output fb_pkg::colour_t              vga_colour
);
    fb_pkg::scan_pos_t           pos;      // current raster position
    fb_pkg::fb_cfg_t             cfg;
    fb_pkg::fb_wr_t              fb_wr;    // pixel write from apb
    logic [fb_pkg::FB_ADDRW-1:0] rd_addr;
    logic                        rd_data;

    display_timings u_timings (.clk_pix, .reset, .pos);

    // 160x120 one bit framebuffer
    bram_sdp u_fb (.clk_pix, .wr(fb_wr), .rd_addr, .rd_data);

    fb_regs u_regs (
        .clk_pix, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .cfg, .fb_wr
    );

    fb_scanout u_scanout (
        .clk_pix, .reset,
        .pos, .cfg,
        .rd_addr, .rd_data,
        .vga_hsync, .vga_vsync, .vga_colour
    );
endmodule

// File: tests/tb_fb_display.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// runs about three frames, raster position recovered from the sync pins
// pixel checks start only after the first vsync rise
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_fb_display;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYCLES    = fb_pkg::H_TOTAL * fb_pkg::V_TOTAL;
    localparam int WATCHDOG_CYCLES = 3 * FRAME_CYCLES + 20000;  // frames plus apb traffic

    logic clk_pix, reset, psel, penable, pwrite, pready, pslverr;
    logic [fb_pkg::APB_ADDRW-1:0] paddr;
    logic [31:0] pwdata, prdata;
    logic vga_hsync, vga_vsync;
    fb_pkg::colour_t vga_colour;

    logic model [0:fb_pkg::FB_PIXELS-1];  // reference framebuffer
    logic m_enable;
    fb_pkg::colour_t m_fg, m_bg;
    int m_addr;
    int seed = 84512;
    int hcnt, vcnt, vs_rises, phase;  // phase 1 pixel frame, 2 display off
    logic hs_d, vs_d, locked;
    string cur_test;
    int errs_by[string];
    int total_errs = 0;

    fb_display_top u_dut (.*);

    initial begin
        clk_pix = 1'b0;
        forever #20 clk_pix = ~clk_pix;  // 25 MHz
    end

    // hcnt counts cycles since the hsync rise, vcnt lines since the vsync rise
    always @(posedge clk_pix) begin
        if (reset) begin
            hs_d <= 1'b1;
            vs_d <= 1'b1;
            hcnt <= 0;
            vcnt <= 0;
            locked <= 1'b0;
            vs_rises <= 0;
        end else begin
            hs_d <= vga_hsync;
            vs_d <= vga_vsync;
            if (vga_hsync && !hs_d) hcnt <= 1;  // rise was hcnt 0
            else hcnt <= (hcnt == fb_pkg::H_TOTAL - 1) ? 0 : hcnt + 1;
            if (vga_vsync && !vs_d) begin
                vcnt <= 0;
                locked <= 1'b1;
                vs_rises <= vs_rises + 1;
            end else if (hcnt == fb_pkg::H_BP - 1) begin  // next pin is sx 0
                vcnt <= (vcnt == fb_pkg::V_TOTAL - 1) ? 0 : vcnt + 1;
            end
        end
    end

    task automatic log_mismatch(string test, string check, logic [31:0] expv, logic [31:0] actv);
        errs_by[test] = errs_by.exists(test) ? errs_by[test] + 1 : 1;
        total_errs++;
        $display("Fail %s %s: expected 0x%0h actual 0x%0h", test, check, expv, actv);
    endtask

    function automatic logic visible(int hc, int vc);
        return hc >= fb_pkg::H_BP && hc < fb_pkg::H_BP + fb_pkg::H_RES &&
               vc >= fb_pkg::V_BP && vc < fb_pkg::V_BP + fb_pkg::V_RES;
    endfunction

    function automatic fb_pkg::colour_t expect_pixel(int hc, int vc);
        int px, py;
        px = hc - fb_pkg::H_BP;
        py = vc - fb_pkg::V_BP;
        if (!m_enable || px >= fb_pkg::FB_WIDTH || py >= fb_pkg::FB_HEIGHT) return '0;
        return model[py * fb_pkg::FB_WIDTH + px] ? m_fg : m_bg;
    endfunction

    function automatic logic [31:0] expect_prdata(logic [fb_pkg::APB_ADDRW-1:0] addr);
        case (addr)
            fb_pkg::REG_CTRL:    return {31'b0, m_enable};
            fb_pkg::REG_FG:      return {20'b0, m_fg};
            fb_pkg::REG_BG:      return {20'b0, m_bg};
            fb_pkg::REG_FB_ADDR: return 32'(m_addr);
            default:             return '0;
        endcase
    endfunction

    function automatic logic expect_err(logic [fb_pkg::APB_ADDRW-1:0] addr, logic wr);
        logic mapped;
        mapped = addr inside {fb_pkg::REG_CTRL, fb_pkg::REG_FG, fb_pkg::REG_BG,
                              fb_pkg::REG_FB_ADDR, fb_pkg::REG_FB_DATA};
        return !mapped || (!wr && addr == fb_pkg::REG_FB_DATA);  // fb_data is write only
    endfunction

    a_reset: assert property (@(posedge clk_pix)
        reset |=> (vga_colour == '0) && vga_hsync && vga_vsync && !pslverr
    ) else log_mismatch("reset_state", "pins", 32'h3,
                        {$sampled(vga_colour), $sampled(vga_hsync), $sampled(vga_vsync)});
    a_hsync: assert property (@(posedge clk_pix) disable iff (!locked)
        vga_hsync == (hcnt < fb_pkg::H_TOTAL - fb_pkg::H_SYNC)  // low for the last 96
    ) else log_mismatch("sync_timing", "hsync",
                        $sampled(hcnt) < fb_pkg::H_TOTAL - fb_pkg::H_SYNC, $sampled(vga_hsync));
    a_vsync: assert property (@(posedge clk_pix) disable iff (!locked)
        vga_vsync == (vcnt < fb_pkg::V_TOTAL - fb_pkg::V_SYNC)
    ) else log_mismatch("sync_timing", "vsync",
                        $sampled(vcnt) < fb_pkg::V_TOTAL - fb_pkg::V_SYNC, $sampled(vga_vsync));
    a_blank: assert property (@(posedge clk_pix) disable iff (!locked)
        !visible(hcnt, vcnt) |-> vga_colour == '0
    ) else log_mismatch("sync_timing", "blank colour", 0, $sampled(vga_colour));
    a_pixel: assert property (@(posedge clk_pix) disable iff (!locked)
        (phase == 1) && visible(hcnt, vcnt) |-> vga_colour == expect_pixel(hcnt, vcnt)
    ) else log_mismatch("pixel_scanout", "colour",
                        expect_pixel($sampled(hcnt), $sampled(vcnt)), $sampled(vga_colour));
    a_off: assert property (@(posedge clk_pix) disable iff (!locked)
        (phase == 2) |-> vga_colour == '0
    ) else log_mismatch("display_off", "colour", 0, $sampled(vga_colour));
    a_pready: assert property (@(posedge clk_pix) disable iff (reset) pready)
        else log_mismatch(cur_test, "pready", 1, pready);
    a_pslverr: assert property (@(posedge clk_pix) disable iff (reset)
        psel && penable |-> pslverr == expect_err(paddr, pwrite)
    ) else log_mismatch(cur_test, "pslverr", expect_err(paddr, pwrite), pslverr);
    a_prdata: assert property (@(posedge clk_pix) disable iff (reset)
        psel && penable && !pwrite && !expect_err(paddr, 1'b0) |-> prdata == expect_prdata(paddr)
    ) else log_mismatch(cur_test, "prdata", expect_prdata(paddr), prdata);

    // setup then access, called 5 ns after a rising edge
    task automatic apb_write(logic [fb_pkg::APB_ADDRW-1:0] addr, logic [31:0] data);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clk_pix);
        #5;
        penable = 1'b1;
        @(posedge clk_pix);
        #5;
        psel = 1'b0;
        penable = 1'b0;
        case (addr)  // mirror the write in the model
            fb_pkg::REG_CTRL:    m_enable = data[0];
            fb_pkg::REG_FG:      m_fg = fb_pkg::colour_t'(data[11:0]);
            fb_pkg::REG_BG:      m_bg = fb_pkg::colour_t'(data[11:0]);
            fb_pkg::REG_FB_ADDR: m_addr = (data[14:0] < fb_pkg::FB_PIXELS) ? int'(data[14:0]) : 0;
            fb_pkg::REG_FB_DATA: begin
                model[m_addr] = data[0];
                m_addr = (m_addr + 1) % fb_pkg::FB_PIXELS;
            end
            default: ;
        endcase
    endtask

    task automatic apb_read(logic [fb_pkg::APB_ADDRW-1:0] addr);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clk_pix);
        #5;
        penable = 1'b1;  // prdata checked by assertion here
        @(posedge clk_pix);
        #5;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_registers();
        apb_read(fb_pkg::REG_CTRL);
        apb_read(fb_pkg::REG_FG);
        apb_read(fb_pkg::REG_BG);
        apb_read(fb_pkg::REG_FB_ADDR);
    endtask

    // random bits from start, then address readback
    task automatic write_pixels(int start, int count);
        apb_write(fb_pkg::REG_FB_ADDR, 32'(start));
        repeat (count) apb_write(fb_pkg::REG_FB_DATA, 32'($random(seed) & 1));
        apb_read(fb_pkg::REG_FB_ADDR);
    endtask

    task automatic finish_test(string name);
        $display("%s finished with %0d errors", name, errs_by.exists(name) ? errs_by[name] : 0);
    endtask

    initial begin
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        phase = 0;
        m_enable = 1'b0;
        m_fg = '0;
        m_bg = '0;
        m_addr = 0;
        cur_test = "reset_state";
        for (int i = 0; i < fb_pkg::FB_PIXELS; i++) model[i] = 1'b0;  // ram starts cleared
        repeat (2) @(posedge clk_pix);
        #5 reset = 1'b0;
        @(posedge clk_pix);  // last reset check samples this edge
        #5 finish_test("reset_state");
        cur_test = "register_access";
        read_registers();  // all zero after reset
        apb_write(fb_pkg::REG_FG, 32'hABCD_EF80);  // upper bits dropped
        apb_write(fb_pkg::REG_BG, 32'h0000_004A);
        apb_write(fb_pkg::REG_FB_ADDR, 32'd1234);
        apb_write(fb_pkg::REG_CTRL, 32'h1);
        read_registers();
        apb_read(8'h20);  // unmapped
        apb_read(fb_pkg::REG_FB_DATA);
        apb_write(8'h14, 32'hFFFF_FFFF);
        read_registers();  // error transfers changed nothing
        finish_test("register_access");
        cur_test = "address_increment";
        write_pixels(0, 200);
        write_pixels(fb_pkg::FB_WIDTH * 60 + 80, 64);
        write_pixels(fb_pkg::FB_PIXELS - 1, 6);  // wraps to 0
        write_pixels(fb_pkg::FB_WIDTH * 119, fb_pkg::FB_WIDTH);  // last row
        finish_test("address_increment");
        cur_test = "pixel_scanout";
        wait (vs_rises == 1);
        phase = 1;  // whole next frame checked
        wait (vs_rises == 2);
        #5 finish_test("pixel_scanout");
        cur_test = "display_off";
        apb_write(fb_pkg::REG_CTRL, 32'h0);  // lands in vertical back porch
        phase = 2;
        apb_read(fb_pkg::REG_CTRL);
        wait (vs_rises == 3);
        phase = 0;
        finish_test("display_off");
        finish_test("sync_timing");
        $display("tests run: 6, errors: %0d", total_errs);
        if (total_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_pix);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end
endmodule

// File: fb_display.f
logic/fb_pkg.sv
logic/display_timings.sv
logic/bram_sdp.sv
logic/fb_regs.sv
logic/fb_scanout.sv
logic/fb_display_top.sv
tests/tb_fb_display.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the framebuffer display testbench with verilator
# exit status is nonzero when the log holds the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_fb_display -f fb_display.f -o sim_fb_display \
    && ./obj_dir/sim_fb_display | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0
